// File: Bender.yml
package:
  name: mf2

sources:
  - common/mf2_pkg.sv
  - rtl/mf2/mf2_io_snoop.sv
  - rtl/mf2/mf2_control.sv
  - rtl/mf2/mf2_ram.sv
  - rtl/mf2/mf2_top.sv
  - target: test
    files:
      - test/mf2_checker.sv
      - test/mf2_tb.sv

// File: common/mf2_pkg.sv
/*
 * Shared constants and types for the Multiface Two cartridge block.
 * Referenced by scoped name from the RTL and the testbench.
 */
`default_nettype none

package mf2_pkg;

	////////////////////////////////////////
	// Bus widths
	////////////////////////////////////////

	localparam int addr_w = 16; // Z80 address bus
	localparam int data_w = 8;
	localparam int ram_aw = 13; // 8 KB cartridge RAM

	////////////////////////////////////////
	// M1 fetch vectors and paging ports
	////////////////////////////////////////

	localparam logic [addr_w-1:0] nmi_vector  = 16'h0066; // Maps the cartridge in
	localparam logic [addr_w-1:0] hide_vector = 16'h0065; // Hides it while mapped

	// FEE8 pages in, FEEA pages out, bit 1 tells them apart
	localparam logic [addr_w-3:0] page_port_base = 14'h3FBA;

	// High address byte of the snooped hardware ports
	localparam logic [7:0] ga_port       = 8'h7F; // Gate array
	localparam logic [7:0] crtc_sel_port = 8'hBC;
	localparam logic [7:0] crtc_val_port = 8'hBD;
	localparam logic [7:0] ppi_port      = 8'hF7; // 8255
	localparam logic [7:0] rom_port      = 8'hDF; // Upper ROM select

	////////////////////////////////////////
	// Shadow register locations in RAM
	////////////////////////////////////////

	localparam logic [ram_aw-1:0] shadow_pen_sel   = 13'h1FCF;
	localparam logic [ram_aw-1:0] shadow_border    = 13'h1FDF;
	localparam logic [ram_aw-1:0] shadow_pen_base  = 13'h1F90; // Plus pen index
	localparam logic [ram_aw-1:0] shadow_mode      = 13'h1FEF;
	localparam logic [ram_aw-1:0] shadow_bank      = 13'h1FFF;
	localparam logic [ram_aw-1:0] shadow_crtc_sel  = 13'h1CFF;
	localparam logic [ram_aw-1:0] shadow_crtc_base = 13'h1DB0; // Plus CRTC register
	localparam logic [ram_aw-1:0] shadow_ppi       = 13'h17FF;
	localparam logic [ram_aw-1:0] shadow_rom       = 13'h1AAC;

	// CPU address bits 15:13
	localparam logic [2:0] ram_region = 3'd1; // 0x2000 to 0x3FFF
	localparam logic [2:0] rom_region = 3'd0; // 0x0000 to 0x1FFF

	////////////////////////////////////////
	// Gate-array command byte
	////////////////////////////////////////

	// Function field encodings, bits 7:6
	localparam logic [1:0] ga_fn_pen    = 2'b00; // Select pen
	localparam logic [1:0] ga_fn_colour = 2'b01; // Colour for selected pen
	localparam logic [1:0] ga_fn_mode   = 2'b10; // Screen mode and ROM enables
	localparam logic [1:0] ga_fn_bank   = 2'b11; // RAM banking

	// Same data byte seen raw or split into function and payload
	typedef union packed {
		logic [data_w-1:0] raw;
		struct packed {
			logic [1:0] func;
			logic [5:0] payload; // Pen index sits in bits 4:0
		} cmd;
	} ga_cmd_t;

endpackage

`default_nettype wire

// File: filelist.f
common/mf2_pkg.sv
rtl/mf2/mf2_io_snoop.sv
rtl/mf2/mf2_control.sv
rtl/mf2/mf2_ram.sv
rtl/mf2/mf2_top.sv
test/mf2_checker.sv
test/mf2_tb.sv

// File: rtl/mf2/mf2_control.sv
/*
 * NMI, mapping and hidden state of the cartridge. Reacts to M1 fetches
 * at the NMI and hide vectors, to the freeze key and to paging commands.
 */
`timescale 1ns/1ps
`default_nettype none

module mf2_control (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic [mf2_pkg::addr_w-1:0] cpu_addr,
	input  logic                       m1,
	input  logic                       key_nmi,
	input  logic                       page_wr,
	input  logic                       page_in,
	input  logic                       cfg_disable,
	input  logic                       cfg_hide_on_reset,
	output logic                       nmi,
	output logic                       mf2_en
);

	logic m1_q;
	logic key_q;
	logic m1_rise;
	logic key_rise;
	logic hidden; // Cartridge invisible to paging-in

	assign m1_rise  = m1 & ~m1_q;
	assign key_rise = key_nmi & ~key_q;

	always_ff @(posedge clk_sys) begin
		m1_q  <= m1;
		key_q <= key_nmi;
		if (reset) begin
			nmi    <= 1'b0;
			mf2_en <= 1'b0;
			hidden <= cfg_hide_on_reset;
		end else begin
			// Freeze button
			if (key_rise && !mf2_en && !cfg_disable)
				nmi <= 1'b1;

			// CPU takes the NMI, cartridge maps in
			if (m1_rise && nmi && cpu_addr == mf2_pkg::nmi_vector) begin
				mf2_en <= 1'b1;
				hidden <= 1'b0;
				nmi    <= 1'b0;
			end

			if (m1_rise && mf2_en && cpu_addr == mf2_pkg::hide_vector)
				hidden <= 1'b1;

			// Paging out always works, paging in only when visible
			if (page_wr)
				mf2_en <= page_in & ~hidden & ~cfg_disable;
		end
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	// A mapped cartridge never sees a fresh NMI
	a_nmi_arm: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(nmi) |-> !mf2_en)
		else $error("nmi rose while the cartridge is mapped");

endmodule

`default_nettype wire

// File: rtl/mf2/mf2_io_snoop.sv
/*
 * Watches CPU output writes. Paging ports become page commands, and writes
 * to the gate array, CRTC, 8255 and ROM ports become shadow RAM stores.
 */
`timescale 1ns/1ps
`default_nettype none

module mf2_io_snoop (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  logic [mf2_pkg::addr_w-1:0]   cpu_addr,
	input  logic [mf2_pkg::data_w-1:0]   cpu_dout,
	input  logic                         io_wr,
	output logic                         page_wr,
	output logic                         page_in,
	output logic                         store_wr,
	output logic [mf2_pkg::ram_aw-1:0]   store_addr,
	output logic [mf2_pkg::data_w-1:0]   store_data
);

	logic                       io_wr_q;
	logic                       io_wr_rise;
	logic [7:0]                 port_hi;
	mf2_pkg::ga_cmd_t           ga_cmd;
	logic [4:0]                 pen_index;  // Last pen selected on the gate array
	logic [3:0]                 crtc_reg;   // Last CRTC register selected
	logic                       is_page;
	logic                       is_store;
	logic [mf2_pkg::ram_aw-1:0] shadow_addr;

	assign io_wr_rise = io_wr & ~io_wr_q;
	assign port_hi    = cpu_addr[mf2_pkg::addr_w-1:8];
	assign ga_cmd.raw = cpu_dout;
	assign is_page    = (cpu_addr[mf2_pkg::addr_w-1:2] == mf2_pkg::page_port_base);

	////////////////////////////////////////
	// Port decode to shadow location
	////////////////////////////////////////

	always_comb begin
		is_store    = 1'b1;
		shadow_addr = '0;
		case (port_hi)
			mf2_pkg::ga_port: begin
				case (ga_cmd.cmd.func)
					mf2_pkg::ga_fn_pen:    shadow_addr = mf2_pkg::shadow_pen_sel;
					mf2_pkg::ga_fn_colour: begin
						// Pen 16 and up is the border
						if (pen_index[4])
							shadow_addr = mf2_pkg::shadow_border;
						else
							shadow_addr = mf2_pkg::shadow_pen_base + {9'd0, pen_index[3:0]};
					end
					mf2_pkg::ga_fn_mode:   shadow_addr = mf2_pkg::shadow_mode;
					default:               shadow_addr = mf2_pkg::shadow_bank;
				endcase
			end
			mf2_pkg::crtc_sel_port: shadow_addr = mf2_pkg::shadow_crtc_sel;
			mf2_pkg::crtc_val_port: shadow_addr = mf2_pkg::shadow_crtc_base + {9'd0, crtc_reg};
			mf2_pkg::ppi_port:      shadow_addr = mf2_pkg::shadow_ppi;
			mf2_pkg::rom_port:      shadow_addr = mf2_pkg::shadow_rom;
			default:                is_store = 1'b0; // Not a snooped port
		endcase
	end

	////////////////////////////////////////
	// Command strobes and selection state
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		io_wr_q <= io_wr;
		if (reset) begin
			page_wr   <= 1'b0;
			store_wr  <= 1'b0;
			pen_index <= '0;
			crtc_reg  <= '0;
		end else begin
			page_wr  <= io_wr_rise & is_page;
			store_wr <= io_wr_rise & is_store;
			if (io_wr_rise && port_hi == mf2_pkg::ga_port &&
				ga_cmd.cmd.func == mf2_pkg::ga_fn_pen) begin
				pen_index <= ga_cmd.cmd.payload[4:0];
			end
			if (io_wr_rise && port_hi == mf2_pkg::crtc_sel_port)
				crtc_reg <= cpu_dout[3:0];
		end
	end

	// Payload captured alongside the strobes
	always_ff @(posedge clk_sys) begin
		if (io_wr_rise) begin
			page_in    <= ~cpu_addr[1]; // FEE8 in, FEEA out
			store_addr <= shadow_addr;
			store_data <= cpu_dout;
		end
	end

	// Paging ports and snooped ports never decode from the same write
	a_one_cmd: assert property (@(posedge clk_sys) disable iff (reset)
		!(store_wr && page_wr))
		else $error("snoop issued a page command and a store together");

endmodule

`default_nettype wire

// File: rtl/mf2/mf2_ram.sv
/*
 * 8 KB cartridge RAM. One registered port, shared between shadow stores
 * and CPU accesses, with stores taking priority.
 */
`timescale 1ns/1ps
`default_nettype none

module mf2_ram (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic [mf2_pkg::addr_w-1:0] cpu_addr,
	input  logic [mf2_pkg::data_w-1:0] cpu_dout,
	input  logic                       mem_wr,
	input  logic                       mf2_en,
	input  logic                       store_wr,
	input  logic [mf2_pkg::ram_aw-1:0] store_addr,
	input  logic [mf2_pkg::data_w-1:0] store_data,
	output logic [mf2_pkg::data_w-1:0] read_data
);

	logic [mf2_pkg::data_w-1:0] mem [0:(2**mf2_pkg::ram_aw)-1];

	logic [mf2_pkg::ram_aw-1:0] ram_a;
	logic [mf2_pkg::data_w-1:0] ram_in;
	logic                       ram_we;
	logic                       cpu_in_ram;

	assign cpu_in_ram = (cpu_addr[mf2_pkg::addr_w-1:mf2_pkg::ram_aw] == mf2_pkg::ram_region);

	////////////////////////////////////////
	// Port arbitration
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset)
			ram_we <= 1'b0;
		else
			ram_we <= store_wr | (mem_wr & mf2_en & cpu_in_ram);
	end

	// Store wins over the CPU
	always_ff @(posedge clk_sys) begin
		if (store_wr) begin
			ram_a  <= store_addr;
			ram_in <= store_data;
		end else begin
			ram_a  <= cpu_addr[mf2_pkg::ram_aw-1:0];
			ram_in <= cpu_dout;
		end
	end

	////////////////////////////////////////
	// Array
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			mem[ram_a] <= ram_in;
			read_data  <= ram_in; // Write-through
		end else begin
			read_data  <= mem[ram_a];
		end
	end

endmodule

`default_nettype wire

// File: rtl/mf2/mf2_top.sv
/*
 * Multiface Two cartridge on the CPU bus. Combines the port snooper,
 * the control state and the RAM, and drives the cartridge's data-bus share.
 */
`timescale 1ns/1ps
`default_nettype none

module mf2_top (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic [mf2_pkg::addr_w-1:0] cpu_addr,
	input  logic [mf2_pkg::data_w-1:0] cpu_dout,
	input  logic                       m1,
	input  logic                       io_wr,
	input  logic                       mem_wr,
	input  logic                       mem_rd,
	input  logic                       key_nmi,
	input  logic                       cfg_disable,
	input  logic                       cfg_hide_on_reset,
	output logic                       nmi,
	output logic                       mf2_en,
	output logic                       rom_sel,
	output logic [mf2_pkg::data_w-1:0] mf2_dout
);

	logic                       page_wr;
	logic                       page_in;
	logic                       store_wr;
	logic [mf2_pkg::ram_aw-1:0] store_addr;
	logic [mf2_pkg::data_w-1:0] store_data;
	logic [mf2_pkg::data_w-1:0] read_data;
	logic [2:0]                 region;

	assign region = cpu_addr[mf2_pkg::addr_w-1:mf2_pkg::ram_aw];

	////////////////////////////////////////
	// Blocks
	////////////////////////////////////////

	mf2_io_snoop u_io_snoop (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cpu_addr   (cpu_addr),
		.cpu_dout   (cpu_dout),
		.io_wr      (io_wr),
		.page_wr    (page_wr),
		.page_in    (page_in),
		.store_wr   (store_wr),
		.store_addr (store_addr),
		.store_data (store_data)
	);

	mf2_control u_control (
		.clk_sys           (clk_sys),
		.reset             (reset),
		.cpu_addr          (cpu_addr),
		.m1                (m1),
		.key_nmi           (key_nmi),
		.page_wr           (page_wr),
		.page_in           (page_in),
		.cfg_disable       (cfg_disable),
		.cfg_hide_on_reset (cfg_hide_on_reset),
		.nmi               (nmi),
		.mf2_en            (mf2_en)
	);

	mf2_ram u_ram (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cpu_addr   (cpu_addr),
		.cpu_dout   (cpu_dout),
		.mem_wr     (mem_wr),
		.mf2_en     (mf2_en),
		.store_wr   (store_wr),
		.store_addr (store_addr),
		.store_data (store_data),
		.read_data  (read_data)
	);

	// ROM image lives outside, only the select is produced here
	assign rom_sel = mf2_en & (region == mf2_pkg::rom_region);

	// All ones when idle so it ANDs into the shared data bus
	assign mf2_dout = (mf2_en && mem_rd && region == mf2_pkg::ram_region) ? read_data : 8'hFF;

endmodule

`default_nettype wire

// File: test/mf2_cases.txt
# kind  addr  data  nmi  en  dout  name     (kinds io m1 mw mr key cfg, values in hex)
# cfg data bit 0 is cfg_disable, bit 1 is cfg_hide_on_reset
cfg  0000  01  0  0  FF  cfg_disable_on
key  0000  00  0  0  FF  key_while_disabled
io   FEE8  00  0  0  FF  page_in_while_disabled
cfg  0000  00  0  0  FF  cfg_disable_off
io   7F00  03  0  0  FF  ga_pen_select
io   7F00  45  0  0  FF  ga_pen_colour
io   BC00  0C  0  0  FF  crtc_reg_select
io   BD00  30  0  0  FF  crtc_reg_value
mr   3F93  00  0  0  FF  read_while_unmapped
key  0000  00  1  0  FF  key_arms_nmi
m1   0066  00  0  1  FF  nmi_vector_fetch
mr   3F93  00  0  1  45  read_pen_shadow
mr   3DBC  00  0  1  30  read_crtc_shadow
mw   2010  A5  0  1  FF  ram_write
mr   2010  00  0  1  A5  ram_readback
mr   0010  00  0  1  FF  read_outside_ram
key  0000  00  0  1  FF  key_while_mapped
io   FEEA  00  0  0  FF  page_out
io   FEE8  00  0  1  FF  page_in
m1   0065  00  0  1  FF  hide_vector_fetch
io   FEEA  00  0  0  FF  page_out_hidden
io   FEE8  00  0  0  FF  page_in_hidden
mr   2010  00  0  0  FF  read_after_hide

// File: test/mf2_checker.sv
/*
 * Testbench checker. Compares the DUT's nmi, mf2_en, rom_sel and mf2_dout
 * with expected values when the stimulus asks for a check, and keeps the counts.
 */
`timescale 1ns/1ps
`default_nettype none

module mf2_checker (
	input logic                       clk_sys,
	input logic [mf2_pkg::addr_w-1:0] cpu_addr,
	input logic [mf2_pkg::data_w-1:0] cpu_dout,
	input logic                       io_wr,
	input logic                       nmi,
	input logic                       mf2_en,
	input logic                       rom_sel,
	input logic [mf2_pkg::data_w-1:0] mf2_dout
);

	int               pass_count = 0;
	int               fail_count = 0;
	int               ga_writes = 0;     // Gate-array commands seen on the bus
	int               colour_writes = 0;
	logic             io_wr_q = 1'b0;
	mf2_pkg::ga_cmd_t bus_byte;

	////////////////////////////////////////
	// Bus monitor
	////////////////////////////////////////

	always @(posedge clk_sys) begin
		bus_byte = cpu_dout;
		if (io_wr && !io_wr_q && cpu_addr[15:8] == mf2_pkg::ga_port) begin
			ga_writes++;
			if (bus_byte.cmd.func == mf2_pkg::ga_fn_colour)
				colour_writes++;
		end
		io_wr_q <= io_wr;
	end

	////////////////////////////////////////
	// Comparison and reporting
	////////////////////////////////////////

	task automatic check_op(input logic [8*24-1:0] name, input logic exp_nmi,
		input logic exp_en, input logic [7:0] exp_dout);
		logic exp_rom;
		exp_rom = exp_en && cpu_addr < 16'h2000; // Lower 8 KB while mapped
		if (nmi === exp_nmi && mf2_en === exp_en && rom_sel === exp_rom &&
			mf2_dout === exp_dout) begin
			pass_count++;
			$display("ok  %0s nmi=%b en=%b rom=%b dout=%02h",
				name, nmi, mf2_en, rom_sel, mf2_dout);
		end else begin
			fail_count++;
			$display("ERR %0s expected nmi=%b en=%b rom=%b dout=%02h, actual nmi=%b en=%b rom=%b dout=%02h",
				name, exp_nmi, exp_en, exp_rom, exp_dout, nmi, mf2_en, rom_sel, mf2_dout);
		end
	endtask

	task automatic summarize();
		$display("Tests run %0d, passed %0d, failed %0d; gate-array writes %0d (%0d colour)",
			pass_count + fail_count, pass_count, fail_count, ga_writes, colour_writes);
	endtask

endmodule

`default_nettype wire

// File: test/mf2_tb.sv
/*
 * Testbench for the Multiface Two block. Reads bus operations from the
 * cases file, drives them on falling edges and lets the checker compare.
 */
`timescale 1ns/1ps
`default_nettype none

module mf2_tb;

	localparam int max_cases       = 64;
	localparam int reset_cycles    = 16;
	localparam int clocks_per_case = 12; // Each operation takes six

	logic                       clk_sys;
	logic                       reset;
	logic [mf2_pkg::addr_w-1:0] cpu_addr;
	logic [mf2_pkg::data_w-1:0] cpu_dout;
	logic                       m1;
	logic                       io_wr;
	logic                       mem_wr;
	logic                       mem_rd;
	logic                       key_nmi;
	logic                       cfg_disable;
	logic                       cfg_hide_on_reset;
	logic                       nmi;
	logic                       mf2_en;
	logic                       rom_sel;
	logic [mf2_pkg::data_w-1:0] mf2_dout;

	// Case table, filled before reset ends
	logic [8*8-1:0]  op_kind [0:max_cases-1];
	logic [15:0]     op_addr [0:max_cases-1];
	logic [7:0]      op_data [0:max_cases-1];
	logic            op_nmi  [0:max_cases-1];
	logic            op_en   [0:max_cases-1];
	logic [7:0]      op_dout [0:max_cases-1];
	logic [8*24-1:0] op_name [0:max_cases-1];
	int              n_cases = 0;
	int              bad_lines = 0;
	logic            cases_loaded = 1'b0;

	mf2_top u_mf2_top (
		.clk_sys           (clk_sys),
		.reset             (reset),
		.cpu_addr          (cpu_addr),
		.cpu_dout          (cpu_dout),
		.m1                (m1),
		.io_wr             (io_wr),
		.mem_wr            (mem_wr),
		.mem_rd            (mem_rd),
		.key_nmi           (key_nmi),
		.cfg_disable       (cfg_disable),
		.cfg_hide_on_reset (cfg_hide_on_reset),
		.nmi               (nmi),
		.mf2_en            (mf2_en),
		.rom_sel           (rom_sel),
		.mf2_dout          (mf2_dout)
	);

	mf2_checker u_checker (
		.clk_sys  (clk_sys),
		.cpu_addr (cpu_addr),
		.cpu_dout (cpu_dout),
		.io_wr    (io_wr),
		.nmi      (nmi),
		.mf2_en   (mf2_en),
		.rom_sel  (rom_sel),
		.mf2_dout (mf2_dout)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys; // 100 ns period
	end

	////////////////////////////////////////
	// Case file and bus operations
	////////////////////////////////////////

	task automatic load_cases();
		int              fd;
		int              code;
		logic [8*8-1:0]  kind;
		logic [8*120-1:0] rest;
		fd = $fopen("test/mf2_cases.txt", "r");
		if (fd == 0) begin
			$display("Could not open the case file test/mf2_cases.txt");
			bad_lines++;
			return;
		end
		while (!$feof(fd) && n_cases < max_cases) begin
			code = $fscanf(fd, "%s", kind);
			if (code != 1)
				break;
			if (kind == "#") begin
				code = $fgets(rest, fd); // Column description
			end else begin
				code = $fscanf(fd, "%h %h %h %h %h %s", op_addr[n_cases], op_data[n_cases],
					op_nmi[n_cases], op_en[n_cases], op_dout[n_cases], op_name[n_cases]);
				if (code != 6) begin
					$display("Case line %0d is incomplete or malformed", n_cases + 1);
					bad_lines++;
					break;
				end
				op_kind[n_cases] = kind;
				n_cases++;
			end
		end
		$fclose(fd);
	endtask

	// Raise one strobe, hold it four clocks
	task automatic apply_op(input logic [8*8-1:0] kind, input logic [15:0] addr,
		input logic [7:0] data);
		cpu_addr = addr;
		cpu_dout = data;
		case (kind)
			"io":  io_wr = 1'b1;
			"m1":  m1 = 1'b1;
			"mw":  mem_wr = 1'b1;
			"mr":  mem_rd = 1'b1;
			"key": key_nmi = 1'b1;
			"cfg": begin
				cfg_disable       = data[0];
				cfg_hide_on_reset = data[1];
			end
			default: begin
				$display("Unknown operation kind %0s in the case file", kind);
				bad_lines++;
			end
		endcase
		repeat (4) @(negedge clk_sys);
	endtask

	task automatic release_strobes();
		io_wr   = 1'b0;
		m1      = 1'b0;
		mem_wr  = 1'b0;
		mem_rd  = 1'b0;
		key_nmi = 1'b0;
		repeat (2) @(negedge clk_sys);
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		reset             = 1'b1;
		cpu_addr          = '0;
		cpu_dout          = '0;
		m1                = 1'b0;
		io_wr             = 1'b0;
		mem_wr            = 1'b0;
		mem_rd            = 1'b0;
		key_nmi           = 1'b0;
		cfg_disable       = 1'b0;
		cfg_hide_on_reset = 1'b0;
		load_cases();
		cases_loaded = 1'b1;
		repeat (reset_cycles) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);
		for (int i = 0; i < n_cases; i++) begin
			apply_op(op_kind[i], op_addr[i], op_data[i]);
			u_checker.check_op(op_name[i], op_nmi[i], op_en[i], op_dout[i]);
			release_strobes();
		end
		u_checker.summarize();
		if (u_checker.fail_count == 0 && bad_lines == 0 && n_cases > 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	// Watchdog sized from the case count
	initial begin
		wait (cases_loaded);
		repeat (reset_cycles + clocks_per_case * n_cases) @(posedge clk_sys);
		$display("Watchdog expired, the test sequence did not finish in time");
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
